// File: sim/cpu_stim.txt
# L word-address instruction (hex)   E register (decimal) value (hex)
# G writeback count then run   P cycle to drop run   R reset
L 00 20010005
L 01 2002fffd
L 02 00221820
L 03 3044fff0
L 04 2845ffff
L 05 3c061234
L 06 00c43825
L 07 20200007
L 08 00074022
L 09 15080005
L 0a 10a50002
L 0b 20090111
L 0c 20090222
L 0d 08000010
L 0e 20090333
L 0f 20090444
L 10 01054820
L 11 08000011
E 1 00000005
E 2 fffffffd
E 3 00000002
E 4 0000fff0
E 5 00000001
E 6 12340000
E 7 1234fff0
E 8 edcb0010
E 9 edcb0011
G 9
R
P 11
G 9
R
L 00 00221820
L 01 346400ff
L 02 08000002
E 3 00000000
E 4 000000ff
G 2

// File: files.f
rtl/cpu_pkg.sv
rtl/instr_fetch.sv
rtl/control_decoder.sv
rtl/register_file.sv
rtl/operand_stage.sv
rtl/execute_unit.sv
rtl/cpu_top.sv
sim/clock_gen.sv
sim/tb_cpu_top.sv

// File: run_sim.sh
#!/bin/sh
# verilator build and run of the cpu testbench
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
        --top-module tb_cpu_top -f files.f

./obj_dir/Vtb_cpu_top > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
        echo "simulation failed, see sim.log"
        exit 1
fi
echo "simulation passed"

// File: sim/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top import cpu_pkg::*; ();

        localparam int WAIT_LIMIT = 300;        // cycles before a wait gives up
        localparam int PAUSE_LEN  = 3;          // cycles with run low on a P line
        localparam int SETTLE     = 8;          // quiet cycles watched after a run

        logic       clk, arst_n, reset_req;
        logic       load_en, run;
        imem_addr_t load_addr;
        word_t      load_data;
        logic       wb_valid;
        reg_idx_t   wb_reg;
        word_t      wb_data;

        reg_idx_t   exp_reg [$];                // expected writebacks in program order
        word_t      exp_data [$];
        logic       list_closed;                // next E line starts a new list
        logic       aborted;
        int         wb_total;                   // writebacks seen since time 0, monitor only
        int         run_base;                   // wb_total when the current run began
        int         mon_errors, errors, timeouts;
        int         seed, pause_at;

        clock_gen u_clk (.reset_req, .clk, .arst_n);

        cpu_top dut (
                .clk, .arst_n, .load_en, .load_addr, .load_data, .run,
                .wb_valid, .wb_reg, .wb_data
        );

        function automatic int seen_in_run();
                return wb_total - run_base;
        endfunction

        // writebacks compared at the falling edge, away from register updates
        always @(negedge clk) begin
                int idx;
                if (arst_n && wb_valid) begin
                        idx = wb_total - run_base;
                        assert (idx < exp_reg.size()) else begin
                                mon_errors++;
                                $display("unexpected writeback to r%0d at %0t", wb_reg, $time);
                        end
                        if (idx < exp_reg.size()) begin
                                assert (wb_reg == exp_reg[idx] && wb_data == exp_data[idx])
                                else begin
                                        mon_errors++;
                                        $display("mismatch at %0t: writeback %0d is r%0d=%h, %s%0d=%h",
                                                 $time, idx, wb_reg, wb_data, "expected r",
                                                 exp_reg[idx], exp_data[idx]);
                                end
                        end
                        wb_total++;
                end
        end

        task automatic next_cycle();
                @(posedge clk);
                #1;                             // inputs change just after the edge
        endtask

        task automatic wait_reset_release();
                int n;
                n = 0;
                while (!arst_n && n < WAIT_LIMIT) begin
                        next_cycle();
                        n++;
                end
                if (!arst_n) begin
                        timeouts++;
                        aborted = 1'b1;
                        $display("timeout: reset was never released");
                end
                assert (!wb_valid) else begin
                        errors++;
                        $display("writeback active right after reset at %0t", $time);
                end
        endtask

        task automatic load_word(input imem_addr_t addr, input word_t data);
                int gap;
                gap = $unsigned($random(seed)) % 4;     // 0 to 3 idle cycles
                repeat (gap) next_cycle();
                load_en   = 1'b1;
                load_addr = addr;
                load_data = data;
                assert (!wb_valid) else begin
                        errors++;
                        $display("writeback seen while loading at %0t", $time);
                end
                next_cycle();
                load_en = 1'b0;
        endtask

        task automatic run_program(input int count);
                int cyc;
                run_base    = wb_total;
                list_closed = 1'b1;
                cyc         = 0;
                run         = 1'b1;
                while (seen_in_run() < count && cyc < WAIT_LIMIT) begin
                        next_cycle();
                        cyc++;
                        if (pause_at > 0 && cyc == pause_at) run = 1'b0;   // hold fetch
                        if (pause_at > 0 && cyc == pause_at + PAUSE_LEN) run = 1'b1;
                end
                if (seen_in_run() < count) begin
                        timeouts++;
                        aborted = 1'b1;
                        $display("timeout: only %0d of %0d writebacks arrived",
                                 seen_in_run(), count);
                end else begin
                        run = 1'b1;
                        repeat (SETTLE) next_cycle();   // program parks in a self jump
                        assert (seen_in_run() == exp_reg.size()) else begin
                                errors++;
                                $display("run gave %0d writebacks but %0d were expected",
                                         seen_in_run(), exp_reg.size());
                        end
                end
                run      = 1'b0;
                pause_at = 0;
        endtask

        task automatic apply_reset();
                run       = 1'b0;
                reset_req = 1'b1;
                next_cycle();
                reset_req = 1'b0;
                wait_reset_release();
        endtask

        initial begin
                int               fd, code, reg_v, count;
                logic [7:0]       tag;
                word_t            addr_v, data_v;
                logic [8*128-1:0] rest;

                seed        = 32'h1795_2bda;
                load_en     = 1'b0;
                load_addr   = '0;
                load_data   = '0;
                run         = 1'b0;
                reset_req   = 1'b0;
                list_closed = 1'b1;
                aborted     = 1'b0;
                wb_total    = 0;
                run_base    = 0;
                mon_errors  = 0;
                errors      = 0;
                timeouts    = 0;
                pause_at    = 0;

                next_cycle();
                wait_reset_release();
                fd = $fopen("sim/cpu_stim.txt", "r");
                if (fd == 0) begin
                        errors++;
                        aborted = 1'b1;
                        $display("could not open the stimulus file sim/cpu_stim.txt");
                end

                // one tagged line per step
                while (!aborted) begin
                        code = $fscanf(fd, "%s", tag);
                        if (code != 1) break;   // end of file
                        case (tag)
                        "#": void'($fgets(rest, fd));
                        "L": begin
                                code = $fscanf(fd, "%h %h", addr_v, data_v);
                                load_word(addr_v[5:0], data_v);
                        end
                        "E": begin
                                code = $fscanf(fd, "%d %h", reg_v, data_v);
                                if (list_closed) begin
                                        exp_reg.delete();
                                        exp_data.delete();
                                        list_closed = 1'b0;
                                end
                                exp_reg.push_back(reg_v[4:0]);
                                exp_data.push_back(data_v);
                        end
                        "P": code = $fscanf(fd, "%d", pause_at);
                        "G": begin
                                code = $fscanf(fd, "%d", count);
                                run_program(count);
                        end
                        "R": apply_reset();
                        default: begin
                                errors++;
                                $display("unknown tag %s in the stimulus file", tag);
                        end
                        endcase
                end
                if (fd != 0) $fclose(fd);

                $display("writeback errors %0d, other errors %0d, timeouts %0d",
                         mon_errors, errors, timeouts);
                if (mon_errors == 0 && errors == 0 && timeouts == 0) begin
                        $display("ALL CHECKS PASSED");
                end else begin
                        $display("CHECKS FAILED");
                end
                $finish;
        end

endmodule

// File: sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
        input  logic reset_req,
        output logic clk,
        output logic arst_n
);

        initial clk = 1'b0;
        always #4 clk = ~clk;                   // 8 ns period

        // reset low for 2 rising edges, at start and again on each request
        initial begin
                arst_n = 1'b0;
                forever begin
                        repeat (2) @(posedge clk);
                        @(negedge clk);
                        arst_n = 1'b1;          // release mid-cycle, clear of the edge
                        @(posedge reset_req);
                        arst_n = 1'b0;          // async assert
                end
        end

endmodule

// File: rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
        input  logic       clk,
        input  logic       arst_n,
        input  logic       load_en,
        input  imem_addr_t load_addr,
        input  word_t      load_data,
        input  logic       run,
        output logic       wb_valid,
        output reg_idx_t   wb_reg,
        output word_t      wb_data
);

        // fetch/decode
        word_t    id_instr, id_pc;
        logic     id_valid;
        // decode outputs
        alu_op_t  alu_op;
        logic     use_imm, zero_ext, writes_rd, writes_rt, is_beq, is_bne, is_jump;
        word_t    rs_data, rt_data;
        // decode/execute
        logic     ex_valid, ex_writes, ex_is_beq, ex_is_bne, ex_is_jump;
        alu_op_t  ex_alu_op;
        word_t    ex_a, ex_b, ex_target;
        reg_idx_t ex_dest;
        // execute feedback
        logic     ex_fwd_valid, redirect;
        reg_idx_t ex_fwd_reg;
        word_t    ex_fwd_data, redirect_pc;

        instr_fetch u_fetch (
                .clk, .arst_n, .load_en, .load_addr, .load_data, .run,
                .redirect, .redirect_pc, .id_instr, .id_pc, .id_valid
        );

        control_decoder u_ctrl (
                .id_instr, .alu_op, .use_imm, .zero_ext, .writes_rd, .writes_rt,
                .is_beq, .is_bne, .is_jump
        );

        register_file u_regs (
                .clk, .arst_n,
                .rs_idx  (id_instr[RS_MSB:RS_LSB]),
                .rt_idx  (id_instr[RT_MSB:RT_LSB]),
                .rs_data, .rt_data,
                .wr_en   (wb_valid),    // writes one edge after the wb register
                .wr_idx  (wb_reg),
                .wr_data (wb_data)
        );

        operand_stage u_opnd (
                .clk, .arst_n, .id_instr, .id_pc, .id_valid,
                .alu_op, .use_imm, .zero_ext, .writes_rd, .writes_rt, .is_beq, .is_bne, .is_jump,
                .rs_data, .rt_data, .ex_fwd_valid, .ex_fwd_reg, .ex_fwd_data,
                .wb_valid, .wb_reg, .wb_data, .redirect,
                .ex_valid, .ex_alu_op, .ex_a, .ex_b, .ex_dest, .ex_writes,
                .ex_is_beq, .ex_is_bne, .ex_is_jump, .ex_target
        );

        execute_unit u_exec (
                .clk, .arst_n, .ex_valid, .ex_alu_op, .ex_a, .ex_b, .ex_dest, .ex_writes,
                .ex_is_beq, .ex_is_bne, .ex_is_jump, .ex_target,
                .ex_fwd_valid, .ex_fwd_reg, .ex_fwd_data, .redirect, .redirect_pc,
                .wb_valid, .wb_reg, .wb_data
        );

endmodule

// File: rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import cpu_pkg::*; (
        input  logic     clk,
        input  logic     arst_n,
        input  logic     ex_valid,
        input  alu_op_t  ex_alu_op,
        input  word_t    ex_a,
        input  word_t    ex_b,
        input  reg_idx_t ex_dest,
        input  logic     ex_writes,
        input  logic     ex_is_beq,
        input  logic     ex_is_bne,
        input  logic     ex_is_jump,
        input  word_t    ex_target,
        output logic     ex_fwd_valid,
        output reg_idx_t ex_fwd_reg,
        output word_t    ex_fwd_data,
        output logic     redirect,
        output word_t    redirect_pc,
        output logic     wb_valid,
        output reg_idx_t wb_reg,
        output word_t    wb_data
);

        word_t alu_result;
        logic  operands_eq;
        logic  taken;

        // alu
        always_comb begin
                case (ex_alu_op)
                ALU_ADD: alu_result = ex_a + ex_b;
                ALU_SUB: alu_result = ex_a - ex_b;
                ALU_AND: alu_result = ex_a & ex_b;
                ALU_OR:  alu_result = ex_a | ex_b;
                ALU_SLT: alu_result = {31'd0, $signed(ex_a) < $signed(ex_b)};
                ALU_LUI: alu_result = {ex_b[15:0], 16'h0000};  // imm up by 16
                default: alu_result = ex_a;                    // pass
                endcase
        end

        // branch resolution
        assign operands_eq = (ex_a == ex_b);
        assign taken = ex_valid &&
                       ((ex_is_beq && operands_eq) ||
                        (ex_is_bne && !operands_eq) ||
                        ex_is_jump);

        // one-cycle pulse, flushes fetch/decode and decode/execute
        assign redirect    = taken;
        assign redirect_pc = ex_target;

        // forward to decode, r0 results dropped
        assign ex_fwd_valid = ex_valid && ex_writes && (ex_dest != '0);
        assign ex_fwd_reg   = ex_dest;
        assign ex_fwd_data  = alu_result;

        // writeback register
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        wb_valid <= 1'b0;
                end else begin
                        wb_valid <= ex_fwd_valid;       // branches and jumps never write
                end
        end

        always_ff @(posedge clk) begin
                wb_reg  <= ex_dest;
                wb_data <= alu_result;
        end

endmodule

// File: rtl/operand_stage.sv
`timescale 1ns/1ps

module operand_stage import cpu_pkg::*; (
        input  logic     clk,
        input  logic     arst_n,
        input  word_t    id_instr,
        input  word_t    id_pc,
        input  logic     id_valid,
        input  alu_op_t  alu_op,
        input  logic     use_imm,
        input  logic     zero_ext,
        input  logic     writes_rd,
        input  logic     writes_rt,
        input  logic     is_beq,
        input  logic     is_bne,
        input  logic     is_jump,
        input  word_t    rs_data,
        input  word_t    rt_data,
        input  logic     ex_fwd_valid,
        input  reg_idx_t ex_fwd_reg,
        input  word_t    ex_fwd_data,
        input  logic     wb_valid,
        input  reg_idx_t wb_reg,
        input  word_t    wb_data,
        input  logic     redirect,
        output logic     ex_valid,
        output alu_op_t  ex_alu_op,
        output word_t    ex_a,
        output word_t    ex_b,
        output reg_idx_t ex_dest,
        output logic     ex_writes,
        output logic     ex_is_beq,
        output logic     ex_is_bne,
        output logic     ex_is_jump,
        output word_t    ex_target
);

        reg_idx_t    rs_idx, rt_idx, rd_idx;
        logic [15:0] imm;
        word_t       imm_ext, rs_fwd, rt_fwd, pc_plus4, br_target, j_target;

        assign rs_idx = id_instr[RS_MSB:RS_LSB];
        assign rt_idx = id_instr[RT_MSB:RT_LSB];
        assign rd_idx = id_instr[RD_MSB:RD_LSB];
        assign imm    = id_instr[IMM_MSB:IMM_LSB];

        // newest value first: execute, then writeback, then the regfile
        assign rs_fwd = (ex_fwd_valid && ex_fwd_reg == rs_idx && rs_idx != '0) ? ex_fwd_data :
                        (wb_valid && wb_reg == rs_idx && rs_idx != '0) ? wb_data : rs_data;
        assign rt_fwd = (ex_fwd_valid && ex_fwd_reg == rt_idx && rt_idx != '0) ? ex_fwd_data :
                        (wb_valid && wb_reg == rt_idx && rt_idx != '0) ? wb_data : rt_data;

        assign imm_ext   = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
        assign pc_plus4  = id_pc + 32'd4;
        assign br_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};     // always signed offset
        assign j_target  = {pc_plus4[31:28], id_instr[JIDX_MSB:JIDX_LSB], 2'b00};

        // decode/execute control, bubble on flush
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        ex_valid   <= 1'b0;
                        ex_writes  <= 1'b0;
                        ex_is_beq  <= 1'b0;
                        ex_is_bne  <= 1'b0;
                        ex_is_jump <= 1'b0;
                end else begin
                        ex_valid   <= id_valid && !redirect;
                        ex_writes  <= writes_rd || writes_rt;
                        ex_is_beq  <= is_beq;
                        ex_is_bne  <= is_bne;
                        ex_is_jump <= is_jump;
                end
        end

        // decode/execute payload
        always_ff @(posedge clk) begin
                ex_alu_op <= alu_op;
                ex_a      <= rs_fwd;
                ex_b      <= use_imm ? imm_ext : rt_fwd;  // branches keep rt for compare
                ex_dest   <= writes_rd ? rd_idx : rt_idx;
                ex_target <= is_jump ? j_target : br_target;
        end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
        input  logic     clk,
        input  logic     arst_n,
        input  reg_idx_t rs_idx,
        input  reg_idx_t rt_idx,
        output word_t    rs_data,
        output word_t    rt_data,
        input  logic     wr_en,
        input  reg_idx_t wr_idx,
        input  word_t    wr_data
);

        word_t regs [NUM_REGS];

        // write on the edge, r0 never written
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        for (int i = 0; i < NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wr_en && wr_idx != '0) begin
                        regs[wr_idx] <= wr_data;
                end
        end

        // async reads, no bypass here (operand_stage forwards from wb)
        assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
        assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

// File: rtl/control_decoder.sv
`timescale 1ns/1ps

module control_decoder import cpu_pkg::*; (
        input  word_t   id_instr,
        output alu_op_t alu_op,
        output logic    use_imm,
        output logic    zero_ext,
        output logic    writes_rd,
        output logic    writes_rt,
        output logic    is_beq,
        output logic    is_bne,
        output logic    is_jump
);

        logic [5:0] opcode;
        logic [5:0] funct;

        assign opcode = id_instr[OPCODE_MSB:OPCODE_LSB];
        assign funct  = id_instr[FUNCT_MSB:FUNCT_LSB];

        always_comb begin
                // defaults act as a no-op
                alu_op    = ALU_PASS;
                use_imm   = 1'b0;
                zero_ext  = 1'b0;
                writes_rd = 1'b0;
                writes_rt = 1'b0;
                is_beq    = 1'b0;
                is_bne    = 1'b0;
                is_jump   = 1'b0;

                case (opcode)
                OP_RTYPE: begin
                        writes_rd = 1'b1;
                        case (funct)
                        FN_ADD:  alu_op = ALU_ADD;
                        FN_SUB:  alu_op = ALU_SUB;
                        FN_AND:  alu_op = ALU_AND;
                        FN_OR:   alu_op = ALU_OR;
                        FN_SLT:  alu_op = ALU_SLT;
                        default: writes_rd = 1'b0;      // unknown funct, incl. sll nop
                        endcase
                end
                OP_ADDI: begin
                        alu_op    = ALU_ADD;
                        use_imm   = 1'b1;
                        writes_rt = 1'b1;
                end
                OP_ANDI, OP_ORI: begin
                        alu_op    = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                        use_imm   = 1'b1;
                        zero_ext  = 1'b1;       // logical immediates zero extend
                        writes_rt = 1'b1;
                end
                OP_SLTI: begin
                        alu_op    = ALU_SLT;    // signed compare
                        use_imm   = 1'b1;
                        writes_rt = 1'b1;
                end
                OP_LUI: begin
                        alu_op    = ALU_LUI;
                        use_imm   = 1'b1;
                        zero_ext  = 1'b1;
                        writes_rt = 1'b1;
                end
                OP_BEQ:  is_beq  = 1'b1;        // compares rs and rt in execute
                OP_BNE:  is_bne  = 1'b1;
                OP_J:    is_jump = 1'b1;
                default: ;                      // unknown opcode
                endcase
        end

endmodule

// File: rtl/instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch import cpu_pkg::*; (
        input  logic       clk,
        input  logic       arst_n,
        input  logic       load_en,
        input  imem_addr_t load_addr,
        input  word_t      load_data,
        input  logic       run,
        input  logic       redirect,
        input  word_t      redirect_pc,
        output word_t      id_instr,
        output word_t      id_pc,
        output logic       id_valid
);

        word_t      imem [IMEM_DEPTH];  // no reset, contents survive arst_n
        word_t      pc;                 // byte address
        imem_addr_t fetch_idx;
        word_t      fetch_word;

        assign fetch_idx  = pc[7:2];    // word index, wraps at 64
        assign fetch_word = imem[fetch_idx];  // async read

        // load port, only while stopped
        always_ff @(posedge clk) begin
                if (load_en && !run) begin
                        imem[load_addr] <= load_data;
                end
        end

        // pc update
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        pc <= '0;
                end else if (redirect) begin
                        pc <= redirect_pc;      // taken branch or jump, even when stopped
                end else if (run) begin
                        pc <= pc + 32'd4;
                end
                // run low: pc holds, resumes at the same word
        end

        // fetch/decode valid
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        id_valid <= 1'b0;
                end else begin
                        id_valid <= run && !redirect;   // bubble when stopped or flushed
                end
        end

        // payload of fetch/decode
        always_ff @(posedge clk) begin
                id_instr <= fetch_word;
                id_pc    <= pc;
        end

endmodule

// File: rtl/cpu_pkg.sv
package cpu_pkg;

        typedef logic [31:0] word_t;            // data or instruction word
        typedef logic [4:0]  reg_idx_t;         // register number
        typedef logic [5:0]  imem_addr_t;       // instruction memory word address

        // alu operations, 3 bits
        typedef enum logic [2:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_SLT,
                ALU_LUI,
                ALU_PASS
        } alu_op_t;

        localparam int IMEM_DEPTH = 64;         // words of instruction memory
        localparam int NUM_REGS   = 32;

        // opcodes, mips values
        localparam logic [5:0] OP_RTYPE = 6'h00;
        localparam logic [5:0] OP_J     = 6'h02;
        localparam logic [5:0] OP_BEQ   = 6'h04;
        localparam logic [5:0] OP_BNE   = 6'h05;
        localparam logic [5:0] OP_ADDI  = 6'h08;
        localparam logic [5:0] OP_SLTI  = 6'h0a;
        localparam logic [5:0] OP_ANDI  = 6'h0c;
        localparam logic [5:0] OP_ORI   = 6'h0d;
        localparam logic [5:0] OP_LUI   = 6'h0f;

        // r-type function codes
        localparam logic [5:0] FN_ADD = 6'h20;
        localparam logic [5:0] FN_SUB = 6'h22;
        localparam logic [5:0] FN_AND = 6'h24;
        localparam logic [5:0] FN_OR  = 6'h25;
        localparam logic [5:0] FN_SLT = 6'h2a;

        // field positions in the instruction word
        localparam int OPCODE_MSB = 31, OPCODE_LSB = 26;
        localparam int RS_MSB = 25, RS_LSB = 21;
        localparam int RT_MSB = 20, RT_LSB = 16;
        localparam int RD_MSB = 15, RD_LSB = 11;
        localparam int FUNCT_MSB = 5, FUNCT_LSB = 0;
        localparam int IMM_MSB = 15, IMM_LSB = 0;
        localparam int JIDX_MSB = 25, JIDX_LSB = 0;

endpackage
